/* execute_stage.sv */
module execute_stage (
    input  logic              clk,
    input  pito_pkg::dec_ex_t dec_ex,
    output pito_pkg::ex_mem_t ex_mem
);
    import pito_pkg::*;

    localparam int DMEM_AW = $bits(dmem_addr_t);

    word_t alu_res;
    logic  rs_eq;
    logic  taken;

    // ==================================================================
    // alu
    // ==================================================================
    always_comb begin
        case (dec_ex.op)
            OP_ADD:  alu_res = dec_ex.rs1_val + dec_ex.rs2_val;
            OP_SUB:  alu_res = dec_ex.rs1_val - dec_ex.rs2_val;
            OP_AND:  alu_res = dec_ex.rs1_val & dec_ex.rs2_val;
            OP_OR:   alu_res = dec_ex.rs1_val | dec_ex.rs2_val;
            OP_XOR:  alu_res = dec_ex.rs1_val ^ dec_ex.rs2_val;
            OP_SLT:  alu_res = word_t'($signed(dec_ex.rs1_val) < $signed(dec_ex.rs2_val));
            // addi and the load/store address share the adder
            OP_ADDI: alu_res = dec_ex.rs1_val + dec_ex.imm;
            OP_LW:   alu_res = dec_ex.rs1_val + dec_ex.imm;
            OP_SW:   alu_res = dec_ex.rs1_val + dec_ex.imm;
            OP_LUI:  alu_res = dec_ex.imm;
            // link value
            OP_JAL:  alu_res = dec_ex.pc + pc_t'(4);
            default: alu_res = '0;
        endcase
    end

    // ==================================================================
    // branch resolve
    // ==================================================================
    assign rs_eq = (dec_ex.rs1_val == dec_ex.rs2_val);

    always_comb begin
        case (dec_ex.op)
            OP_JAL:  taken = 1'b1;
            OP_BEQ:  taken = rs_eq;
            OP_BNE:  taken = !rs_eq;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_mem.hart       <= dec_ex.hart;
        ex_mem.op         <= dec_ex.op;
        ex_mem.rd         <= dec_ex.rd;
        ex_mem.result     <= alu_res;
        ex_mem.store_data <= dec_ex.rs2_val;
        // byte address to word address
        ex_mem.addr       <= alu_res[DMEM_AW+1:2];
        ex_mem.redirect   <= taken;
        ex_mem.next_pc    <= dec_ex.pc + dec_ex.imm;
    end

endmodule

/* fetch_decode.sv */
`include "pito_params.svh"

module fetch_decode (
    input  logic                         clk,
    input  logic                         pito_io_rst_n,
    input  logic                         pito_io_program,
    input  pito_pkg::imem_addr_t         pito_io_imem_addr,
    input  pito_pkg::instr_t             pito_io_imem_data,
    input  logic                         pito_io_imem_w_en,
    input  pito_pkg::pc_t                hart_pc      [`PITO_NUM_HARTS],
    input  pito_pkg::word_t              hart_rs1_val [`PITO_NUM_HARTS],
    input  pito_pkg::word_t              hart_rs2_val [`PITO_NUM_HARTS],
    output logic [`PITO_NUM_HARTS-1:0]   fetch_en,
    output pito_pkg::reg_addr_t          rs1_addr,
    output pito_pkg::reg_addr_t          rs2_addr,
    output pito_pkg::dec_ex_t            dec_ex
);
    import pito_pkg::*;

    localparam int IMEM_AW = $bits(imem_addr_t);
    localparam int RA_W    = $bits(reg_addr_t);

    // major opcodes
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    instr_t     imem [`PITO_IMEM_WORDS];
    hart_id_t   hart_cnt;
    hart_id_t   dec_hart;
    logic       dec_valid;
    pc_t        fetch_pc;
    imem_addr_t fetch_addr;
    pc_t        dec_pc;
    instr_t     instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv32_op_e   op;
    word_t      imm;

    // ==================================================================
    // fetch
    // ==================================================================
    // round robin, held at hart 0 while programming
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n || pito_io_program) begin
            hart_cnt  <= '0;
            dec_valid <= 1'b0;
        end else begin
            hart_cnt  <= hart_cnt + 1'b1;
            dec_valid <= 1'b1;
        end
    end

    // fetching hart steps its own pc
    assign fetch_en   = {{(`PITO_NUM_HARTS-1){1'b0}}, 1'b1} << hart_cnt;
    assign fetch_pc   = hart_pc[hart_cnt];
    assign fetch_addr = fetch_pc[IMEM_AW+1:2];

    // io write port, sync read port
    always_ff @(posedge clk) begin
        if (pito_io_imem_w_en) begin
            imem[pito_io_imem_addr] <= pito_io_imem_data;
        end
        instr    <= imem[fetch_addr];
        dec_pc   <= fetch_pc;
        dec_hart <= hart_cnt;
    end

    // ==================================================================
    // decode
    // ==================================================================
    assign opcode   = instr[6:0];
    assign funct3   = instr[`PITO_FUNCT3_LSB +: 3];
    assign funct7   = instr[`PITO_FUNCT7_LSB +: 7];
    assign rs1_addr = instr[`PITO_RS1_LSB +: RA_W];
    assign rs2_addr = instr[`PITO_RS2_LSB +: RA_W];

    always_comb begin
        op  = OP_NOP;
        imm = '0;
        case (opcode)
            OPC_REG: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b010:  op = OP_SLT;
                        3'b100:  op = OP_XOR;
                        3'b110:  op = OP_OR;
                        3'b111:  op = OP_AND;
                        default: op = OP_NOP;
                    endcase
                end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
                    op = OP_SUB;
                end
            end
            OPC_IMM: begin
                // i-type
                imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b000) begin
                    op = OP_ADDI;
                end
            end
            OPC_LUI: begin
                op  = OP_LUI;
                imm = {instr[31:12], 12'b0};
            end
            OPC_LOAD: begin
                imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b010) begin
                    op = OP_LW;
                end
            end
            OPC_STORE: begin
                // s-type, split immediate
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (funct3 == 3'b010) begin
                    op = OP_SW;
                end
            end
            OPC_BRANCH: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op = OP_BNE;
                end
            end
            OPC_JAL: begin
                op  = OP_JAL;
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: op = OP_NOP;
        endcase
    end

    // register read comes from the decoding hart's context
    always_ff @(posedge clk) begin
        dec_ex.hart    <= dec_hart;
        dec_ex.rd      <= instr[`PITO_RD_LSB +: RA_W];
        dec_ex.rs1_val <= hart_rs1_val[dec_hart];
        dec_ex.rs2_val <= hart_rs2_val[dec_hart];
        dec_ex.imm     <= imm;
        dec_ex.pc      <= dec_pc;
        // bubble while reset or programming
        if (!pito_io_rst_n || !dec_valid) begin
            dec_ex.op <= OP_NOP;
        end else begin
            dec_ex.op <= op;
        end
    end

endmodule

/* hart_state.sv */
`include "pito_params.svh"

module hart_state #(
    parameter pito_pkg::hart_id_t HART_ID = '0
) (
    input  logic                   clk,
    input  logic                   pito_io_rst_n,
    input  logic                   fetch_en,
    input  pito_pkg::regf_write_t  regf_wr,
    input  pito_pkg::pc_redirect_t pc_redir,
    input  pito_pkg::reg_addr_t    rs1_addr,
    input  pito_pkg::reg_addr_t    rs2_addr,
    output pito_pkg::pc_t          pc,
    output pito_pkg::word_t        rs1_val,
    output pito_pkg::word_t        rs2_val
);
    import pito_pkg::*;

    // start of this hart's code region
    localparam pc_t RESET_PC = pc_t'(HART_ID) * pc_t'(`PITO_HART_CODE_BYTES);

    word_t regs [`PITO_NUM_REGS];
    logic  wr_hit;
    logic  redir_hit;

    // only act on broadcasts tagged with this hart
    assign wr_hit    = regf_wr.we && (regf_wr.hart == HART_ID) && (regf_wr.addr != '0);
    assign redir_hit = pc_redir.valid && (pc_redir.hart == HART_ID);

    // pc: redirect wins over sequential step
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            pc <= RESET_PC;
        end else if (redir_hit) begin
            pc <= pc_redir.pc;
        end else if (fetch_en) begin
            pc <= pc + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            regs[regf_wr.addr] <= regf_wr.data;
        end
    end

    // x0 reads as zero
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // a hart's writeback lands four cycles before its next fetch slot
    a_redir_not_on_fetch : assert property (
        @(posedge clk) disable iff (!pito_io_rst_n) !(redir_hit && fetch_en)
    );

endmodule

/* memory_writeback.sv */
`include "pito_params.svh"

module memory_writeback (
    input  logic                   clk,
    input  logic                   pito_io_rst_n,
    input  logic                   pito_io_program,
    input  pito_pkg::dmem_addr_t   pito_io_dmem_addr,
    input  pito_pkg::word_t        pito_io_dmem_data,
    input  logic                   pito_io_dmem_w_en,
    input  pito_pkg::ex_mem_t      ex_mem,
    output pito_pkg::word_t        pito_io_dmem_rdata,
    output pito_pkg::regf_write_t  regf_wr,
    output pito_pkg::pc_redirect_t pc_redir
);
    import pito_pkg::*;

    word_t      dmem [`PITO_DMEM_WORDS];
    word_t      dmem_q;
    dmem_addr_t mem_addr;
    word_t      mem_wdata;
    logic       mem_wen;
    logic       core_store;
    ex_mem_t    wb;

    // ==================================================================
    // memory stage
    // ==================================================================
    // program mode hands both ports to io
    assign core_store = (ex_mem.op == OP_SW) && !pito_io_program;
    assign mem_addr   = pito_io_program ? pito_io_dmem_addr : ex_mem.addr;
    assign mem_wdata  = pito_io_program ? pito_io_dmem_data : ex_mem.store_data;
    assign mem_wen    = pito_io_program ? pito_io_dmem_w_en : core_store;

    always_ff @(posedge clk) begin
        if (mem_wen) begin
            dmem[mem_addr] <= mem_wdata;
        end
        dmem_q <= dmem[mem_addr];
    end

    // read-back and load data share the sync read
    assign pito_io_dmem_rdata = dmem_q;

    // stage register, only control cleared
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            wb.op       <= OP_NOP;
            wb.redirect <= 1'b0;
        end else begin
            wb <= ex_mem;
        end
    end

    // ==================================================================
    // writeback
    // ==================================================================
    always_comb begin
        regf_wr.hart = wb.hart;
        regf_wr.addr = wb.rd;
        regf_wr.data = (wb.op == OP_LW) ? dmem_q : wb.result;
        case (wb.op)
            OP_SW, OP_BEQ, OP_BNE, OP_NOP: regf_wr.we = 1'b0;
            default:                       regf_wr.we = 1'b1;
        endcase
    end

    assign pc_redir.hart  = wb.hart;
    assign pc_redir.valid = wb.redirect;
    assign pc_redir.pc    = wb.next_pc;

    // decode bubbles fill the pipe three cycles into program mode,
    // so no store can still be reaching memory by then
    a_no_store_in_program : assert property (
        @(posedge clk) disable iff (!pito_io_rst_n)
        pito_io_program && $past(pito_io_program, 3) |-> (ex_mem.op != OP_SW)
    );

endmodule

/* pito_core.sv */
`include "pito_params.svh"

module pito_core (
    input  logic                 clk,
    input  logic                 pito_io_rst_n,
    input  pito_pkg::imem_addr_t pito_io_imem_addr,
    input  pito_pkg::instr_t     pito_io_imem_data,
    input  logic                 pito_io_imem_w_en,
    input  pito_pkg::dmem_addr_t pito_io_dmem_addr,
    input  pito_pkg::word_t      pito_io_dmem_data,
    input  logic                 pito_io_dmem_w_en,
    input  logic                 pito_io_program,
    output pito_pkg::word_t      pito_io_dmem_rdata
);
    import pito_pkg::*;

    logic [`PITO_NUM_HARTS-1:0] fetch_en;
    pc_t                        hart_pc      [`PITO_NUM_HARTS];
    word_t                      hart_rs1_val [`PITO_NUM_HARTS];
    word_t                      hart_rs2_val [`PITO_NUM_HARTS];
    reg_addr_t                  rs1_addr;
    reg_addr_t                  rs2_addr;
    dec_ex_t                    dec_ex;
    ex_mem_t                    ex_mem;
    regf_write_t                regf_wr;
    pc_redirect_t               pc_redir;
    logic                       hart_rst_n;

    // pcs sit at region starts while programming
    assign hart_rst_n = pito_io_rst_n && !pito_io_program;

    // ==================================================================
    // pipeline stages
    // ==================================================================
    fetch_decode u_fetch_decode (
        .clk               (clk),
        .pito_io_rst_n     (pito_io_rst_n),
        .pito_io_program   (pito_io_program),
        .pito_io_imem_addr (pito_io_imem_addr),
        .pito_io_imem_data (pito_io_imem_data),
        .pito_io_imem_w_en (pito_io_imem_w_en),
        .hart_pc           (hart_pc),
        .hart_rs1_val      (hart_rs1_val),
        .hart_rs2_val      (hart_rs2_val),
        .fetch_en          (fetch_en),
        .rs1_addr          (rs1_addr),
        .rs2_addr          (rs2_addr),
        .dec_ex            (dec_ex)
    );

    execute_stage u_execute_stage (
        .clk    (clk),
        .dec_ex (dec_ex),
        .ex_mem (ex_mem)
    );

    memory_writeback u_memory_writeback (
        .clk                (clk),
        .pito_io_rst_n      (pito_io_rst_n),
        .pito_io_program    (pito_io_program),
        .pito_io_dmem_addr  (pito_io_dmem_addr),
        .pito_io_dmem_data  (pito_io_dmem_data),
        .pito_io_dmem_w_en  (pito_io_dmem_w_en),
        .ex_mem             (ex_mem),
        .pito_io_dmem_rdata (pito_io_dmem_rdata),
        .regf_wr            (regf_wr),
        .pc_redir           (pc_redir)
    );

    // ==================================================================
    // hart contexts
    // ==================================================================
    // writeback broadcasts, each context filters on its own id
    for (genvar h = 0; h < `PITO_NUM_HARTS; h++) begin : g_hart
        hart_state #(
            .HART_ID (hart_id_t'(h))
        ) u_hart_state (
            .clk           (clk),
            .pito_io_rst_n (hart_rst_n),
            .fetch_en      (fetch_en[h]),
            .regf_wr       (regf_wr),
            .pc_redir      (pc_redir),
            .rs1_addr      (rs1_addr),
            .rs2_addr      (rs2_addr),
            .pc            (hart_pc[h]),
            .rs1_val       (hart_rs1_val[h]),
            .rs2_val       (hart_rs2_val[h])
        );
    end

endmodule

/* pito_params.svh */
`ifndef PITO_PARAMS_SVH
`define PITO_PARAMS_SVH

// hart count and index width
`define PITO_NUM_HARTS        8
`define PITO_HART_W           3

// memory depths, in 32-bit words
`define PITO_IMEM_WORDS       512
`define PITO_DMEM_WORDS       256

// each hart owns one code region, hart h starts at h * region size
`define PITO_HART_CODE_BYTES  256

// datapath and register file
`define PITO_XLEN             32
`define PITO_NUM_REGS         32

// instruction field positions (lsb of each field)
`define PITO_RD_LSB           7
`define PITO_FUNCT3_LSB       12
`define PITO_RS1_LSB          15
`define PITO_RS2_LSB          20
`define PITO_FUNCT7_LSB       25

`endif

/* pito_pkg.sv */
`include "pito_params.svh"

package pito_pkg;

    // ==================================================================
    // plain vector types
    // ==================================================================
    typedef logic [`PITO_HART_W-1:0]               hart_id_t;
    typedef logic [`PITO_XLEN-1:0]                 pc_t;
    typedef logic [31:0]                           instr_t;
    typedef logic [`PITO_XLEN-1:0]                 word_t;
    typedef logic [$clog2(`PITO_NUM_REGS)-1:0]     reg_addr_t;
    typedef logic [$clog2(`PITO_IMEM_WORDS)-1:0]   imem_addr_t;
    typedef logic [$clog2(`PITO_DMEM_WORDS)-1:0]   dmem_addr_t;

    // kept instruction subset, anything else decodes to nop
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } rv32_op_e;

    // ==================================================================
    // stage bundles
    // ==================================================================
    // decode to execute
    typedef struct packed {
        hart_id_t  hart;
        rv32_op_e  op;
        reg_addr_t rd;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        pc_t       pc;
    } dec_ex_t;

    // execute to memory, reused for memory to writeback
    typedef struct packed {
        hart_id_t   hart;
        rv32_op_e   op;
        reg_addr_t  rd;
        word_t      result;
        word_t      store_data;
        dmem_addr_t addr;
        logic       redirect;
        pc_t        next_pc;
    } ex_mem_t;

    // broadcast to every hart context
    typedef struct packed {
        hart_id_t  hart;
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } regf_write_t;

    typedef struct packed {
        hart_id_t hart;
        logic     valid;
        pc_t      pc;
    } pc_redirect_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_pito_core -o tb_pito_core
./obj_dir/tb_pito_core | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* sources.f */
+incdir+.
pito_pkg.sv
hart_state.sv
fetch_decode.sv
execute_stage.sv
memory_writeback.sv
pito_core.sv
tb_pito_core.sv

/* tb_program_image.svh */
`ifndef TB_PROGRAM_IMAGE_SVH
`define TB_PROGRAM_IMAGE_SVH

// rv32 major opcodes used by the test programs
localparam logic [6:0] OPC_REG    = 7'b0110011;
localparam logic [6:0] OPC_IMM    = 7'b0010011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam int         REGION_WORDS = `PITO_HART_CODE_BYTES / 4;

// whole instruction memory image, hart h owns words h*REGION_WORDS onward
instr_t img [`PITO_IMEM_WORDS];
int     img_len [`PITO_NUM_HARTS];

// ======================================================================
// instruction encoders
// ======================================================================
function automatic logic [4:0] reg_field(int r);
    word_t v;
    v = r;
    return v[4:0];
endfunction

function automatic instr_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, reg_field(rs2), reg_field(rs1), f3, reg_field(rd), OPC_REG};
endfunction

function automatic instr_t enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, word_t v);
    return {v[11:0], reg_field(rs1), f3, reg_field(rd), opc};
endfunction

function automatic instr_t enc_s(word_t v, int rs2, int rs1);
    return {v[11:5], reg_field(rs2), reg_field(rs1), 3'b010, v[4:0], 7'b0100011};
endfunction

// branch offset in bytes, bit 0 dropped
function automatic instr_t enc_b(word_t v, int rs2, int rs1, logic [2:0] f3);
    return {v[12], v[10:5], reg_field(rs2), reg_field(rs1), f3, v[4:1], v[11], 7'b1100011};
endfunction

function automatic instr_t enc_u(word_t v, int rd);
    return {v[19:0], reg_field(rd), 7'b0110111};
endfunction

function automatic instr_t enc_j(word_t v, int rd);
    return {v[20], v[10:1], v[11], v[19:12], reg_field(rd), 7'b1101111};
endfunction

// ======================================================================
// image building
// ======================================================================
// unused slots get a nop tagged with its own word address
function automatic void clear_image();
    word_t a;
    for (int i = 0; i < `PITO_IMEM_WORDS; i++) begin
        a = i;
        img[i] = enc_i(OPC_IMM, 3'b000, 0, 0, a);
    end
    for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
        img_len[h] = 0;
    end
endfunction

function automatic void emit_instr(int h, instr_t ins);
    img[h * REGION_WORDS + img_len[h]] = ins;
    img_len[h]++;
endfunction

// byte address of the next instruction of hart h
function automatic int next_pc(int h);
    return (h * REGION_WORDS + img_len[h]) * 4;
endfunction

function automatic void addi(int h, int rd, int rs1, word_t imm);
    emit_instr(h, enc_i(OPC_IMM, 3'b000, rd, rs1, imm));
endfunction

// lui + addi, upper part rounded for the sign of the low 12 bits
function automatic void load_const(int h, int rd, word_t v);
    word_t up;
    up = (v + 32'h800) >> 12;
    emit_instr(h, enc_u(up, rd));
    addi(h, rd, rd, v);
endfunction

// x1 holds the hart's data base, off counts words
function automatic void store_word(int h, int rs2, int off, word_t val);
    emit_instr(h, enc_s(off * 4, rs2, 1));
    exp_mem[h * DATA_WORDS + off] = val;
endfunction

function automatic void set_data_base(int h);
    addi(h, 1, 0, h * DATA_WORDS * 4);
endfunction

// jal x0 to itself
function automatic void halt(int h);
    emit_instr(h, enc_j(0, 0));
endfunction

`endif

/* tb_pito_core.sv */
`include "pito_params.svh"

module tb_pito_core;
    timeunit 1ns;
    timeprecision 1ps;

    import pito_pkg::*;

    localparam int RUN_CYCLES  = 400;
    localparam int DATA_WORDS  = `PITO_DMEM_WORDS / `PITO_NUM_HARTS;
    localparam int PRELOAD_MAX = 4 * `PITO_NUM_HARTS;
    // image load, preload, run, drain and full read-back
    localparam int PROG_TEST_CYCLES = `PITO_IMEM_WORDS + 1 + 2 * PRELOAD_MAX + RUN_CYCLES + 5
                                      + `PITO_DMEM_WORDS + 1;
    localparam int MEM_TEST_CYCLES  = 3 * `PITO_DMEM_WORDS + 1;
    localparam int WATCHDOG_CYCLES  = 3 + MEM_TEST_CYCLES + 5 * PROG_TEST_CYCLES + 200;

    logic        clk;
    logic        pito_io_rst_n;
    imem_addr_t  pito_io_imem_addr;
    instr_t      pito_io_imem_data;
    logic        pito_io_imem_w_en;
    dmem_addr_t  pito_io_dmem_addr;
    word_t       pito_io_dmem_data;
    logic        pito_io_dmem_w_en;
    logic        pito_io_program;
    word_t       pito_io_dmem_rdata;

    // model of data memory contents
    word_t       exp_mem [`PITO_DMEM_WORDS];
    int          err_cnt;
    int          check_cnt;
    int unsigned seed_ret;

    `include "tb_program_image.svh"

    pito_core dut0 (
        .clk                (clk),
        .pito_io_rst_n      (pito_io_rst_n),
        .pito_io_imem_addr  (pito_io_imem_addr),
        .pito_io_imem_data  (pito_io_imem_data),
        .pito_io_imem_w_en  (pito_io_imem_w_en),
        .pito_io_dmem_addr  (pito_io_dmem_addr),
        .pito_io_dmem_data  (pito_io_dmem_data),
        .pito_io_dmem_w_en  (pito_io_dmem_w_en),
        .pito_io_program    (pito_io_program),
        .pito_io_dmem_rdata (pito_io_dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ==================================================================
    // io drivers and checks
    // ==================================================================
    task automatic compare_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_imem_image();
        for (int a = 0; a < `PITO_IMEM_WORDS; a++) begin
            @(negedge clk);
            pito_io_imem_addr = imem_addr_t'(a);
            pito_io_imem_data = img[a];
            pito_io_imem_w_en = 1'b1;
        end
        @(negedge clk);
        pito_io_imem_w_en = 1'b0;
    endtask

    task automatic write_dmem(input int a, input word_t d);
        @(negedge clk);
        pito_io_dmem_addr = dmem_addr_t'(a);
        pito_io_dmem_data = d;
        pito_io_dmem_w_en = 1'b1;
        exp_mem[a] = d;
        @(negedge clk);
        pito_io_dmem_w_en = 1'b0;
    endtask

    // rdata sampled one cycle after each address
    task automatic check_dmem(input string tag);
        for (int a = 0; a <= `PITO_DMEM_WORDS; a++) begin
            @(negedge clk);
            if (a > 0) begin
                compare_word($sformatf("%s pito_io_dmem_rdata[%0d]", tag, a - 1),
                             pito_io_dmem_rdata, exp_mem[a - 1]);
            end
            if (a < `PITO_DMEM_WORDS) begin
                pito_io_dmem_addr = dmem_addr_t'(a);
            end
        end
    endtask

    task automatic load_and_run(input string tag);
        write_imem_image();
        @(negedge clk);
        pito_io_program = 1'b0;
        repeat (RUN_CYCLES) @(negedge clk);
        pito_io_program = 1'b1;
        // slots still in flight drain as bubbles
        repeat (4) @(negedge clk);
        check_dmem(tag);
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================
    task automatic test_dmem_readback();
        for (int a = 0; a < `PITO_DMEM_WORDS; a++) begin
            write_dmem(a, $urandom);
        end
        check_dmem("readback");
    endtask

    task automatic test_alu();
        word_t a;
        word_t b;
        word_t r;
        word_t sx;
        clear_image();
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            a  = $urandom;
            b  = $urandom;
            r  = $urandom;
            sx = {{20{r[11]}}, r[11:0]};
            set_data_base(h);
            load_const(h, 2, a);
            load_const(h, 3, b);
            emit_instr(h, enc_u(r >> 12, 4));
            addi(h, 5, 2, r);
            emit_instr(h, enc_r(7'h00, 3, 2, 3'b000, 6));
            emit_instr(h, enc_r(7'h20, 3, 2, 3'b000, 7));
            emit_instr(h, enc_r(7'h00, 3, 2, 3'b111, 8));
            emit_instr(h, enc_r(7'h00, 3, 2, 3'b110, 9));
            emit_instr(h, enc_r(7'h00, 3, 2, 3'b100, 10));
            emit_instr(h, enc_r(7'h00, 3, 2, 3'b010, 11));
            emit_instr(h, enc_r(7'h00, 2, 3, 3'b010, 12));
            store_word(h, 4, 0, {r[31:12], 12'h000});
            store_word(h, 5, 1, a + sx);
            store_word(h, 6, 2, a + b);
            store_word(h, 7, 3, a - b);
            store_word(h, 8, 4, a & b);
            store_word(h, 9, 5, a | b);
            store_word(h, 10, 6, a ^ b);
            store_word(h, 11, 7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            store_word(h, 12, 8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
            store_word(h, 2, 9, a);
            store_word(h, 3, 10, b);
            halt(h);
        end
        load_and_run("alu");
    endtask

    // words 11..14 preloaded, sums land in 15..18
    task automatic test_load_store();
        word_t r;
        word_t sx;
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            for (int k = 0; k < 4; k++) begin
                write_dmem(h * DATA_WORDS + 11 + k, $urandom);
            end
        end
        clear_image();
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            r  = $urandom;
            sx = {{20{r[11]}}, r[11:0]};
            set_data_base(h);
            for (int k = 0; k < 4; k++) begin
                emit_instr(h, enc_i(OPC_LOAD, 3'b010, 2, 1, (11 + k) * 4));
                addi(h, 3, 2, r);
                store_word(h, 3, 15 + k, exp_mem[h * DATA_WORDS + 11 + k] + sx);
            end
            halt(h);
        end
        load_and_run("load_store");
    endtask

    task automatic test_branch();
        word_t r;
        word_t s;
        word_t init;
        int    n;
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            write_dmem(h * DATA_WORDS + 20, $urandom);
        end
        clear_image();
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            r    = $urandom;
            s    = word_t'(r[6:0]) + 32'd1;
            init = word_t'(r[18:8]);
            n    = 2 + h;
            set_data_base(h);
            addi(h, 2, 0, n);
            addi(h, 3, 0, init);
            addi(h, 5, 0, s);
            // countdown loop, sum += counter
            emit_instr(h, enc_r(7'h00, 2, 3, 3'b000, 3));
            addi(h, 2, 2, -1);
            emit_instr(h, enc_b(-8, 0, 2, 3'b001));
            store_word(h, 3, 19, init + word_t'(n * (n + 1) / 2));
            // taken beq jumps over the store to word 20
            emit_instr(h, enc_b(8, 0, 0, 3'b000));
            emit_instr(h, enc_s(20 * 4, 5, 1));
            // counter is zero, s is not, so this one falls through
            emit_instr(h, enc_b(8, 5, 2, 3'b000));
            store_word(h, 5, 21, s);
            halt(h);
        end
        load_and_run("branch");
    endtask

    task automatic test_jal_link();
        int link;
        clear_image();
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            set_data_base(h);
            link = next_pc(h) + 4;
            emit_instr(h, enc_j(8, 2));
            // skipped, would clobber the link
            addi(h, 2, 0, 0);
            store_word(h, 2, 22, link);
            link = next_pc(h) + 4;
            emit_instr(h, enc_j(12, 3));
            addi(h, 3, 0, 0);
            addi(h, 3, 0, 0);
            store_word(h, 3, 23, link);
            halt(h);
        end
        load_and_run("jal_link");
    endtask

    // top byte carries the hart index so every region is distinct
    task automatic test_isolation_x0();
        word_t hw;
        word_t r;
        word_t v;
        clear_image();
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            hw = h;
            set_data_base(h);
            for (int k = 0; k < 6; k++) begin
                r = $urandom;
                v = {hw[7:0], r[23:0]};
                load_const(h, 2, v);
                store_word(h, 2, 24 + k, v);
            end
            addi(h, 0, 0, 123);
            store_word(h, 0, 30, '0);
            emit_instr(h, enc_u(32'hfffff, 0));
            emit_instr(h, enc_r(7'h00, 2, 2, 3'b000, 0));
            store_word(h, 0, 31, '0);
            halt(h);
        end
        load_and_run("isolation_x0");
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        seed_ret          = $urandom(32'hf9c31530);
        err_cnt           = 0;
        check_cnt         = 0;
        pito_io_rst_n     = 1'b0;
        pito_io_program   = 1'b1;
        pito_io_imem_addr = '0;
        pito_io_imem_data = '0;
        pito_io_imem_w_en = 1'b0;
        pito_io_dmem_addr = '0;
        pito_io_dmem_data = '0;
        pito_io_dmem_w_en = 1'b0;
        repeat (3) @(negedge clk);
        pito_io_rst_n = 1'b1;

        test_dmem_readback();
        test_alu();
        test_load_store();
        test_branch();
        test_jal_link();
        test_isolation_x0();

        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
